// File: Makefile
# Verilator build and run of the AXU load/store pre-decoder testbench

VERILATOR ?= verilator
TOP       ?= axu_dec_tb
RTL_TOP   ?= axu_dec_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= TESTS PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := testbench/axu_dec_model.svh

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/axu_dec_pkg.sv
package axu_dec_pkg;

   // Thread and register pool sizing
   localparam int threads      = 2;
   localparam int threads_enc  = 1;
   localparam int gpr_pool_enc = 6;

   // Writeback tag holds three format flags, the target register and the thread number
   localparam int ldst_tag_w = 3 + gpr_pool_enc + threads_enc;

   // All vectors keep Power numbering, bit 0 is the most significant
   typedef logic [0:31]              instr_t;
   typedef logic [0:threads-1]       tid_t;
   typedef logic [0:threads_enc-1]   tid_enc_t;
   typedef logic [0:gpr_pool_enc-1]  gpr_tag_t;
   typedef logic [0:5]               ldst_size_t;
   typedef logic [0:ldst_tag_w-1]    ldst_tag_t;
   typedef logic [0:15]              dimm_t;

   // Primary opcodes
   localparam logic [0:5] op_x_form    = 6'd31;
   localparam logic [0:5] op_fp_d_base = 6'd48;

   // Extended opcodes of the ex0 predecoded forms
   localparam logic [0:9] xo_extload  = 10'd607;
   localparam logic [0:9] xo_extstore = 10'd735;

   // X-form floating loads and stores
   localparam logic [0:9] xo_lfsx   = 10'd535;
   localparam logic [0:9] xo_lfsux  = 10'd567;
   localparam logic [0:9] xo_lfdx   = 10'd599;
   localparam logic [0:9] xo_lfdux  = 10'd631;
   localparam logic [0:9] xo_stfsx  = 10'd663;
   localparam logic [0:9] xo_stfsux = 10'd695;
   localparam logic [0:9] xo_stfdx  = 10'd727;
   localparam logic [0:9] xo_stfdux = 10'd759;

   // Integer-word forms
   localparam logic [0:9] xo_lfiwax = 10'd855;
   localparam logic [0:9] xo_lfiwzx = 10'd887;
   localparam logic [0:9] xo_stfiwx = 10'd983;

   // One-hot size codes, the set bit gives the access length
   localparam ldst_size_t size_word  = 6'b000100;
   localparam ldst_size_t size_dword = 6'b001000;

endpackage

// File: logic/axu_dec_top.sv
`timescale 1ns/1ps

module axu_dec_top
   import axu_dec_pkg::*;
(
   input  logic       nclk,
   input  logic       arst_n,
   input  instr_t     ex0_instr,
   input  logic       ex0_vld,
   input  tid_t       ex1_tid,
   input  gpr_tag_t   ex1_t3_p,
   output logic       ex0_extload,
   output logic       ex0_extstore,
   output logic       ex1_ldst_v,
   output logic       ex1_st_v,
   output ldst_size_t ex1_ldst_size,
   output logic       ex1_ldst_update,
   output logic       ex1_ldst_indexed,
   output dimm_t      ex1_ldst_dimm,
   output ldst_tag_t  ex1_ldst_tag
);

   instr_t ex1_instr;
   logic   ex1_vld;
   logic   single_ldst;
   logic   int_word_ldst;
   logic   sign_ext_ldst;

   axu_ex0_stage ex0_stage_i (
      .nclk         (nclk),
      .arst_n       (arst_n),
      .ex0_instr    (ex0_instr),
      .ex0_vld      (ex0_vld),
      .ex0_extload  (ex0_extload),
      .ex0_extstore (ex0_extstore),
      .ex1_instr    (ex1_instr),
      .ex1_vld      (ex1_vld)
   );

   axu_ldst_decode ldst_decode_i (
      .ex1_instr     (ex1_instr),
      .ex1_vld       (ex1_vld),
      .ldst_v        (ex1_ldst_v),
      .st_v          (ex1_st_v),
      .update        (ex1_ldst_update),
      .indexed       (ex1_ldst_indexed),
      .size          (ex1_ldst_size),
      .dimm          (ex1_ldst_dimm),
      .single_ldst   (single_ldst),
      .int_word_ldst (int_word_ldst),
      .sign_ext_ldst (sign_ext_ldst)
   );

   // Thread and target come from the queue in ex1 and bypass the latch
   axu_ldst_tag ldst_tag_i (
      .ex1_tid       (ex1_tid),
      .ex1_t3_p      (ex1_t3_p),
      .single_ldst   (single_ldst),
      .int_word_ldst (int_word_ldst),
      .sign_ext_ldst (sign_ext_ldst),
      .ldst_tag      (ex1_ldst_tag)
   );

endmodule

// File: logic/axu_ex0_stage.sv
`timescale 1ns/1ps

module axu_ex0_stage
   import axu_dec_pkg::*;
(
   input  logic   nclk,
   input  logic   arst_n,
   input  instr_t ex0_instr,
   input  logic   ex0_vld,
   output logic   ex0_extload,
   output logic   ex0_extstore,
   output instr_t ex1_instr,
   output logic   ex1_vld
);

   logic       ex0_is_x_form;
   logic [0:9] ex0_xo;

   assign ex0_is_x_form = (ex0_instr[0:5] == op_x_form);
   assign ex0_xo        = ex0_instr[21:30];

   // The load/store queue needs these a cycle early to steer the external-PID path
   assign ex0_extload  = ex0_is_x_form && (ex0_xo == xo_extload);
   assign ex0_extstore = ex0_is_x_form && (ex0_xo == xo_extstore);

   // Only the valid bit is control state here
   always_ff @(posedge nclk or negedge arst_n) begin
      if (!arst_n) begin
         ex1_vld <= 1'b0;
      end else begin
         ex1_vld <= ex0_vld;
      end
   end

   // The instruction moves every cycle, so ex1 always sees last cycle's word
   always_ff @(posedge nclk) begin
      ex1_instr <= ex0_instr;
   end

endmodule

// File: logic/axu_ldst_decode.sv
`timescale 1ns/1ps

module axu_ldst_decode
   import axu_dec_pkg::*;
(
   input  instr_t     ex1_instr,
   input  logic       ex1_vld,
   output logic       ldst_v,
   output logic       st_v,
   output logic       update,
   output logic       indexed,
   output ldst_size_t size,
   output dimm_t      dimm,
   output logic       single_ldst,
   output logic       int_word_ldst,
   output logic       sign_ext_ldst
);

   logic [0:5] pri;
   logic [0:9] xo;
   logic       ld_st;
   logic       dbl;

   assign pri = ex1_instr[0:5];
   assign xo  = ex1_instr[21:30];

   always_comb begin
      ld_st         = 1'b0;
      st_v          = 1'b0;
      update        = 1'b0;
      indexed       = 1'b0;
      dbl           = 1'b0;
      single_ldst   = 1'b0;
      int_word_ldst = 1'b0;
      sign_ext_ldst = 1'b0;

      if (pri[0:2] == op_fp_d_base[0:2]) begin
         // D-form 48 to 55, the low three opcode bits are store, double and update
         ld_st       = 1'b1;
         st_v        = pri[3];
         dbl         = pri[4];
         update      = pri[5];
         single_ldst = !pri[4];
      end else if (pri == op_x_form) begin
         case (xo)
            xo_lfsx, xo_lfsux, xo_lfdx, xo_lfdux,
            xo_stfsx, xo_stfsux, xo_stfdx, xo_stfdux: begin
               // Same three attributes as the D-form twin, two bits further down
               ld_st       = 1'b1;
               indexed     = 1'b1;
               st_v        = xo[2];
               dbl         = xo[3];
               update      = xo[4];
               single_ldst = !xo[3];
            end
            xo_lfiwax: begin
               ld_st         = 1'b1;
               indexed       = 1'b1;
               int_word_ldst = 1'b1;
               sign_ext_ldst = 1'b1;
            end
            xo_lfiwzx: begin
               ld_st         = 1'b1;
               indexed       = 1'b1;
               int_word_ldst = 1'b1;
            end
            xo_stfiwx: begin
               ld_st         = 1'b1;
               indexed       = 1'b1;
               st_v          = 1'b1;
               int_word_ldst = 1'b1;
            end
            default: begin
               ld_st = 1'b0;
            end
         endcase
      end
   end

   // Integer-word forms move a 4-byte word like the singles do
   always_comb begin
      if (!ld_st) begin
         size = '0;
      end else if (dbl) begin
         size = size_dword;
      end else begin
         size = size_word;
      end
   end

   assign ldst_v = ld_st & ex1_vld;

   // Carried for all forms, the queue ignores it on indexed accesses
   assign dimm = ex1_instr[16:31];

endmodule

// File: logic/axu_ldst_tag.sv
`timescale 1ns/1ps

module axu_ldst_tag
   import axu_dec_pkg::*;
(
   input  tid_t      ex1_tid,
   input  gpr_tag_t  ex1_t3_p,
   input  logic      single_ldst,
   input  logic      int_word_ldst,
   input  logic      sign_ext_ldst,
   output ldst_tag_t ldst_tag
);

   tid_enc_t tid_enc;

   // Each active thread bit contributes its own index, so a one-hot vector
   // folds into its binary number
   always_comb begin
      tid_enc = '0;
      for (int i = 0; i < threads; i++) begin
         tid_enc = tid_enc | (tid_enc_t'(i) & {threads_enc{ex1_tid[i]}});
      end
   end

   // Format flags lead so the FPU can pick its conversion before the register lookup
   assign ldst_tag = {single_ldst, int_word_ldst, sign_ext_ldst, ex1_t3_p, tid_enc};

endmodule

// File: testbench/axu_dec_model.svh
`ifndef AXU_DEC_MODEL_SVH
`define AXU_DEC_MODEL_SVH

// Expected ex1 attributes of one instruction before the valid gate
typedef struct packed {
   logic       ldst;
   logic       st;
   logic       upd;
   logic       idx;
   ldst_size_t size;
   logic       single;
   logic       int_word;
   logic       sign_ext;
} ldst_exp_t;

// Bit 1 flags the external-PID load and bit 0 the external-PID store
function automatic logic [1:0] ext_form_flags(instr_t ins);
   logic [15:0] key;
   key = {ins[0:5], ins[21:30]};
   case (key)
      {6'd31, 10'd607}: return 2'b10;
      {6'd31, 10'd735}: return 2'b01;
      default:          return 2'b00;
   endcase
endfunction

function automatic ldst_exp_t predict_decode(instr_t ins);
   ldst_exp_t  e;
   logic [0:5] pri;
   logic [0:9] xo;
   logic       hit;
   logic [2:0] attr;
   e    = '0;
   pri  = ins[0:5];
   xo   = ins[21:30];
   hit  = 1'b1;
   attr = 3'b000;
   if (pri >= 6'd48 && pri <= 6'd55) begin
      e.ldst   = 1'b1;
      e.st     = pri[3];
      e.upd    = pri[5];
      e.single = !pri[4];
      e.size   = pri[4] ? size_dword : size_word;
   end else if (pri == op_x_form) begin
      // Store, double and update bits of each indexed form match its D-form twin
      case (xo)
         xo_lfsx:   attr = 3'b000;
         xo_lfsux:  attr = 3'b001;
         xo_lfdx:   attr = 3'b010;
         xo_lfdux:  attr = 3'b011;
         xo_stfsx:  attr = 3'b100;
         xo_stfsux: attr = 3'b101;
         xo_stfdx:  attr = 3'b110;
         xo_stfdux: attr = 3'b111;
         default:   hit  = 1'b0;
      endcase
      if (hit) begin
         e.ldst   = 1'b1;
         e.idx    = 1'b1;
         e.st     = attr[2];
         e.upd    = attr[0];
         e.single = !attr[1];
         e.size   = attr[1] ? size_dword : size_word;
      end else if (xo == xo_lfiwax || xo == xo_lfiwzx || xo == xo_stfiwx) begin
         e.ldst     = 1'b1;
         e.idx      = 1'b1;
         e.int_word = 1'b1;
         e.size     = size_word;
         e.st       = (xo == xo_stfiwx);
         e.sign_ext = (xo == xo_lfiwax);
      end
   end
   return e;
endfunction

function automatic tid_enc_t thread_number(tid_t tid);
   tid_enc_t n;
   n = '0;
   for (int i = 0; i < threads; i++) begin
      if (tid[i]) n = tid_enc_t'(i);
   end
   return n;
endfunction

function automatic ldst_tag_t assemble_tag(ldst_exp_t e, tid_t tid, gpr_tag_t t3);
   return {e.single, e.int_word, e.sign_ext, t3, thread_number(tid)};
endfunction

// Group 0 is D-form, 1 the X-form list, 2 the ex0 forms, anything else a raw word
function automatic instr_t draw_instr(int unsigned group);
   instr_t      w;
   int unsigned pick;
   w = $urandom;
   case (group)
      0: begin
         w[0:5] = op_fp_d_base + 6'($urandom % 8);
      end
      1: begin
         pick   = $urandom % 11;
         w[0:5] = op_x_form;
         case (pick)
            0:       w[21:30] = xo_lfsx;
            1:       w[21:30] = xo_lfsux;
            2:       w[21:30] = xo_lfdx;
            3:       w[21:30] = xo_lfdux;
            4:       w[21:30] = xo_stfsx;
            5:       w[21:30] = xo_stfsux;
            6:       w[21:30] = xo_stfdx;
            7:       w[21:30] = xo_stfdux;
            8:       w[21:30] = xo_lfiwax;
            9:       w[21:30] = xo_lfiwzx;
            default: w[21:30] = xo_stfiwx;
         endcase
      end
      2: begin
         w[0:5]   = op_x_form;
         w[21:30] = (($urandom % 2) != 0) ? xo_extstore : xo_extload;
      end
      default: begin
         // A raw word keeps every bit as drawn
      end
   endcase
   return w;
endfunction

`endif

// File: testbench/axu_dec_tb.sv
`timescale 1ns/1ps

module axu_dec_tb
   import axu_dec_pkg::*;
();

   localparam int clk_period     = 40;
   localparam int reset_cycles   = 10;
   localparam int num_instr      = 2000;
   localparam int timeout_cycles = reset_cycles + num_instr + 90;

   logic       nclk;
   logic       arst_n;
   instr_t     ex0_instr;
   logic       ex0_vld;
   tid_t       ex1_tid;
   gpr_tag_t   ex1_t3_p;
   logic       ex0_extload;
   logic       ex0_extstore;
   logic       ex1_ldst_v;
   logic       ex1_st_v;
   ldst_size_t ex1_ldst_size;
   logic       ex1_ldst_update;
   logic       ex1_ldst_indexed;
   dimm_t      ex1_ldst_dimm;
   ldst_tag_t  ex1_ldst_tag;

   // Instruction and effective valid of the word now held in the ex1 latch
   instr_t instr_q[$];
   logic   vld_q[$];

   int cycle_count = 0;
   int ldst_hits   = 0;
   int iw_hits     = 0;
   int b2b_tags    = 0;

   `include "axu_dec_model.svh"

   axu_dec_top axu_dec_top_i (
      .nclk             (nclk),
      .arst_n           (arst_n),
      .ex0_instr        (ex0_instr),
      .ex0_vld          (ex0_vld),
      .ex1_tid          (ex1_tid),
      .ex1_t3_p         (ex1_t3_p),
      .ex0_extload      (ex0_extload),
      .ex0_extstore     (ex0_extstore),
      .ex1_ldst_v       (ex1_ldst_v),
      .ex1_st_v         (ex1_st_v),
      .ex1_ldst_size    (ex1_ldst_size),
      .ex1_ldst_update  (ex1_ldst_update),
      .ex1_ldst_indexed (ex1_ldst_indexed),
      .ex1_ldst_dimm    (ex1_ldst_dimm),
      .ex1_ldst_tag     (ex1_ldst_tag)
   );

   always #(clk_period / 2) nclk = ~nclk;

   always @(posedge nclk) begin
      cycle_count++;
      if (cycle_count >= timeout_cycles) begin
         $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
         $display("TESTS FAILED");
         $fatal(1, "simulation timed out");
      end
   end

   task automatic compare_bits(string name, logic [15:0] got, logic [15:0] expected);
      if (got !== expected) begin
         $display("[ERROR] %s: got %h expected %h", name, got, expected);
         $display("TESTS FAILED");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic check_size(string name, ldst_size_t got, ldst_size_t expected);
      if (got !== expected) begin
         $display("[ERROR] %s: got %h expected %h", name, got, expected);
         $display("TESTS FAILED");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic verify_tag(string name, ldst_tag_t got, ldst_tag_t expected);
      if (got !== expected) begin
         $display("[ERROR] %s: got %h expected %h", name, got, expected);
         $display("TESTS FAILED");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic drive_cycle();
      int unsigned group;
      int unsigned thread;
      group     = $urandom % 4;
      ex0_instr = draw_instr(group);
      ex0_vld   = (($urandom % 100) < 80);
      thread    = $urandom % threads;
      ex1_tid   = tid_t'(1) << thread;
      ex1_t3_p  = gpr_tag_t'($urandom);
      instr_q.push_back(ex0_instr);
      // A word latched while reset is low never reaches ex1 as valid
      vld_q.push_back(ex0_vld & arst_n);
   endtask

   task automatic score_outputs();
      instr_t     prev_instr;
      logic       prev_vld;
      ldst_exp_t  exp_dec;
      logic       exp_v;
      logic [1:0] exp_ext;
      exp_ext = ext_form_flags(ex0_instr);
      compare_bits("ex0_extload", 16'(ex0_extload), 16'(exp_ext[1]));
      compare_bits("ex0_extstore", 16'(ex0_extstore), 16'(exp_ext[0]));
      if (instr_q.size() < 2) begin
         compare_bits("ex1_ldst_v", 16'(ex1_ldst_v), 16'h0000);
      end else begin
         prev_instr = instr_q.pop_front();
         prev_vld   = vld_q.pop_front();
         exp_dec    = predict_decode(prev_instr);
         exp_v      = exp_dec.ldst & prev_vld;
         compare_bits("ex1_ldst_v", 16'(ex1_ldst_v), 16'(exp_v));
         if (exp_v) begin
            compare_bits("ex1_st_v", 16'(ex1_st_v), 16'(exp_dec.st));
            compare_bits("ex1_ldst_update", 16'(ex1_ldst_update), 16'(exp_dec.upd));
            compare_bits("ex1_ldst_indexed", 16'(ex1_ldst_indexed), 16'(exp_dec.idx));
            compare_bits("ex1_ldst_dimm", 16'(ex1_ldst_dimm), 16'(prev_instr[16:31]));
            check_size("ex1_ldst_size", ex1_ldst_size, exp_dec.size);
            verify_tag("ex1_ldst_tag", ex1_ldst_tag,
                       assemble_tag(exp_dec, ex1_tid, ex1_t3_p));
            ldst_hits++;
            if (exp_dec.int_word) iw_hits++;
            // A valid word at ex0 behind this one means two are in flight
            if (ex0_vld) b2b_tags++;
         end
      end
   endtask

   initial begin
      nclk      = 1'b0;
      arst_n    = 1'b0;
      ex0_instr = '0;
      ex0_vld   = 1'b0;
      ex1_tid   = '0;
      ex1_t3_p  = '0;
      void'($urandom(32'h1c60));

      // Inputs change on the falling edge and outputs are sampled a quarter period later
      for (int n = 0; n < reset_cycles + num_instr + 1; n++) begin
         @(negedge nclk);
         if (n == reset_cycles) arst_n = 1'b1;
         drive_cycle();
         #(clk_period / 4);
         score_outputs();
      end

      if (ldst_hits == 0 || iw_hits == 0 || b2b_tags == 0) begin
         $display("Stimulus never reached a valid load/store, an integer-word form, or a pair");
         $display("TESTS FAILED");
         $fatal(1, "stimulus did not cover the decode");
      end else begin
         $display("Checked %0d loads and stores, %0d back to back", ldst_hits, b2b_tags);
         $display("TESTS PASSED");
         $finish;
      end
   end

endmodule

// File: verilog.f
+incdir+testbench
logic/axu_dec_pkg.sv
logic/axu_ex0_stage.sv
logic/axu_ldst_decode.sv
logic/axu_ldst_tag.sv
logic/axu_dec_top.sv
testbench/axu_dec_tb.sv
